/* rtl/ntt_params_pkg.sv */
//======================================================================
// Shared definitions for the NTT butterfly engine
// Coefficient and bus widths, the two moduli, the register map and
// the launch controller states. Modules take it by wildcard import
//======================================================================

package ntt_params_pkg;

    //======================================================================
    // Coefficient datapath
    //======================================================================
    // ML-DSA prime needs 23 bits, one more for the carry
    localparam int COEFF_W       = 24;
    localparam int MLKEM_COEFF_W = 12;

    typedef logic [COEFF_W-1:0] coeff_t;

    localparam coeff_t MLDSA_PRIME = 24'd8380417;
    localparam coeff_t MLKEM_PRIME = 24'd3329;

    //======================================================================
    // AXI4-Lite register interface
    //======================================================================
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;

    // Register map, word aligned
    localparam axi_addr_t REG_CTRL   = 8'h00;
    localparam axi_addr_t REG_OPA    = 8'h04;
    localparam axi_addr_t REG_OPB    = 8'h08;
    localparam axi_addr_t REG_STATUS = 8'h0C;
    localparam axi_addr_t REG_SUM    = 8'h10;
    localparam axi_addr_t REG_DIFF   = 8'h14;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Launch controller
    typedef enum logic {
        IDLE,
        WAIT_RESULT
    } ctrl_state_t;

endpackage

/* rtl/ntt_add_sub_mod.sv */
`timescale 1ns/1ps
//======================================================================
// Two-stage modular adder/subtractor for the NTT butterfly
// Computes (opa +/- opb) mod prime_i, latency fixed at two cycles,
// one new operation accepted per cycle. In ML-KEM mode only the low
// 12 bits take part and bit 12 serves as the carry
//======================================================================

module ntt_add_sub_mod
    import ntt_params_pkg::*;
#(
    parameter int REG_SIZE = COEFF_W
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                add_en_i,
    input  logic                sub_i,
    input  logic                mlkem_i,
    input  logic [REG_SIZE-1:0] opa_i,
    input  logic [REG_SIZE-1:0] opb_i,
    input  logic [REG_SIZE-1:0] prime_i,
    output logic [REG_SIZE-1:0] res_o,
    output logic                ready_o
);

    // Keep only the ML-KEM coefficient bits
    function automatic logic [REG_SIZE-1:0] kem_trim(input logic [REG_SIZE-1:0] v);
        logic [REG_SIZE-1:0] t;
        t = '0;
        t[MLKEM_COEFF_W-1:0] = v[MLKEM_COEFF_W-1:0];
        return t;
    endfunction

    // Stage one, opa + opb or opa + ~opb + 1
    logic [REG_SIZE-1:0] opb_x;
    logic [REG_SIZE-1:0] a0;
    logic [REG_SIZE-1:0] b0;
    logic [REG_SIZE:0]   sum0;
    logic                carry0;
    logic [REG_SIZE-1:0] r0_q;
    logic [REG_SIZE-1:0] corr_q;
    logic                carry0_q;
    logic                sub_q;
    logic                mlkem_q;

    // Stage two, correction by the prime and final select
    logic [REG_SIZE-1:0] a1;
    logic [REG_SIZE-1:0] b1;
    logic [REG_SIZE:0]   sum1;
    logic                carry1;
    logic [REG_SIZE-1:0] r1;
    logic                use_corr;
    logic [REG_SIZE-1:0] res_q;
    logic [1:0]          valid_q;

    assign opb_x  = sub_i ? ~opb_i : opb_i;
    assign a0     = mlkem_i ? kem_trim(opa_i) : opa_i;
    assign b0     = mlkem_i ? kem_trim(opb_x) : opb_x;
    assign sum0   = {1'b0, a0} + {1'b0, b0} + {{REG_SIZE{1'b0}}, sub_i};
    assign carry0 = mlkem_i ? sum0[MLKEM_COEFF_W] : sum0[REG_SIZE];

    // Prime is added for subtraction, subtracted for addition
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            r0_q     <= '0;
            corr_q   <= '0;
            carry0_q <= 1'b0;
            sub_q    <= 1'b0;
            mlkem_q  <= 1'b0;
        end else if (add_en_i) begin
            r0_q     <= sum0[REG_SIZE-1:0];
            corr_q   <= sub_i ? prime_i : ~prime_i;
            carry0_q <= carry0;
            sub_q    <= sub_i;
            mlkem_q  <= mlkem_i;
        end
    end

    // Carry out of bit 12 is dropped here in ML-KEM mode
    assign a1     = mlkem_q ? kem_trim(r0_q) : r0_q;
    assign b1     = mlkem_q ? kem_trim(corr_q) : corr_q;
    assign sum1   = {1'b0, a1} + {1'b0, b1} + {{REG_SIZE{1'b0}}, !sub_q};
    assign carry1 = mlkem_q ? sum1[MLKEM_COEFF_W] : sum1[REG_SIZE];
    assign r1     = mlkem_q ? kem_trim(sum1[REG_SIZE-1:0]) : sum1[REG_SIZE-1:0];

    // Sub: borrow means wrap back up by the prime
    // Add: take corrected value when sum reached the prime
    assign use_corr = sub_q ? !carry0_q : (carry0_q ^ carry1);

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            res_q <= '0;
        end else if (valid_q[1]) begin
            res_q <= use_corr ? r1 : a1;
        end
    end

    // Two-bit valid shift register, one slot per stage
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_q <= 2'b00;
        end else if (zeroize_i) begin
            valid_q <= 2'b00;
        end else begin
            valid_q <= {add_en_i, valid_q[1]};
        end
    end

    assign res_o   = res_q;
    assign ready_o = valid_q[0];

    // Every ready pulse traces back to an accepted operation
    assert property (@(posedge clk) disable iff (!reset_n)
        ready_o |-> $past(add_en_i, 2));

    // Result is fully reduced against the prime it was started with
    assert property (@(posedge clk) disable iff (!reset_n)
        ready_o |-> (res_o < $past(prime_i, 2)));

endmodule

/* rtl/ntt_butterfly.sv */
`timescale 1ns/1ps
//======================================================================
// NTT butterfly without twiddle, returns (a+b) mod q and (a-b) mod q
// Prime chosen by the mode bit, both results ready two cycles after
// start_i, one operation per cycle may enter
//======================================================================

module ntt_butterfly
    import ntt_params_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   zeroize_i,
    input  logic   start_i,
    input  logic   mlkem_i,
    input  coeff_t opa_i,
    input  coeff_t opb_i,
    output coeff_t sum_o,
    output coeff_t diff_o,
    output logic   ready_o
);

    coeff_t prime;
    logic   add_ready;
    logic   sub_ready;

    // ML-KEM 3329 or ML-DSA 8380417
    assign prime = mlkem_i ? MLKEM_PRIME : MLDSA_PRIME;

    // Modular sum
    ntt_add_sub_mod #(
        .REG_SIZE (COEFF_W)
    ) u_add (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .add_en_i  (start_i),
        .sub_i     (1'b0),
        .mlkem_i   (mlkem_i),
        .opa_i     (opa_i),
        .opb_i     (opb_i),
        .prime_i   (prime),
        .res_o     (sum_o),
        .ready_o   (add_ready)
    );

    // Modular difference on the same operands
    ntt_add_sub_mod #(
        .REG_SIZE (COEFF_W)
    ) u_sub (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .add_en_i  (start_i),
        .sub_i     (1'b1),
        .mlkem_i   (mlkem_i),
        .opa_i     (opa_i),
        .opb_i     (opb_i),
        .prime_i   (prime),
        .res_o     (diff_o),
        .ready_o   (sub_ready)
    );

    assign ready_o = add_ready;

    // Both halves run in lockstep
    assert property (@(posedge clk) disable iff (!reset_n)
        add_ready == sub_ready);

endmodule

/* rtl/ntt_axil_regs.sv */
`timescale 1ns/1ps
//======================================================================
// AXI4-Lite register block of the butterfly engine
// Holds operands, mode, status and results, and launches one
// butterfly per start write. Unmapped addresses answer SLVERR
//======================================================================

module ntt_axil_regs
    import ntt_params_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    // AXI4-Lite slave
    input  axi_addr_t  s_axil_awaddr_i,
    input  logic       s_axil_awvalid_i,
    output logic       s_axil_awready_o,
    input  axi_data_t  s_axil_wdata_i,
    input  axi_strb_t  s_axil_wstrb_i,
    input  logic       s_axil_wvalid_i,
    output logic       s_axil_wready_o,
    output logic [1:0] s_axil_bresp_o,
    output logic       s_axil_bvalid_o,
    input  logic       s_axil_bready_i,
    input  axi_addr_t  s_axil_araddr_i,
    input  logic       s_axil_arvalid_i,
    output logic       s_axil_arready_o,
    output axi_data_t  s_axil_rdata_o,
    output logic [1:0] s_axil_rresp_o,
    output logic       s_axil_rvalid_o,
    input  logic       s_axil_rready_i,
    // Butterfly side
    input  coeff_t     sum_i,
    input  coeff_t     diff_i,
    input  logic       ready_i,
    output logic       start_o,
    output logic       zeroize_o,
    output logic       mlkem_o,
    output coeff_t     opa_o,
    output coeff_t     opb_o
);

    // Byte lane merge of write data into the old register value
    function automatic axi_data_t merge_strb(input axi_data_t old_v, input axi_data_t new_v,
                                             input axi_strb_t strb);
        axi_data_t m;
        m = old_v;
        for (int i = 0; i < AXI_STRB_W; i++) begin
            if (strb[i]) begin
                m[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return m;
    endfunction

    // Write channel
    logic        aw_ready_q;
    logic        b_valid_q;
    logic [1:0]  b_resp_q;
    logic        wr_en;
    logic        wr_mapped;
    axi_data_t   ctrl_wr;
    // Read channel
    logic        ar_ready_q;
    logic        r_valid_q;
    logic [1:0]  r_resp_q;
    axi_data_t   r_data_q;
    axi_data_t   rd_data;
    logic        rd_mapped;
    logic        rd_en;
    // Control and data registers
    ctrl_state_t state_q;
    logic        busy;
    logic        mlkem_q;
    logic        done_q;
    logic        start_q;
    logic        zeroize_q;
    logic        go;
    logic        zero_req;
    logic        op_wr;
    logic        capture;
    coeff_t      opa_q;
    coeff_t      opb_q;
    coeff_t      sum_q;
    coeff_t      diff_q;

    //======================================================================
    // Decode
    //======================================================================
    assign wr_en     = aw_ready_q && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_en     = ar_ready_q && s_axil_arvalid_i;
    assign wr_mapped = s_axil_awaddr_i inside {REG_CTRL, REG_OPA, REG_OPB,
                                               REG_STATUS, REG_SUM, REG_DIFF};
    // Start and zeroize read back as zero, so merge over mode only
    assign ctrl_wr   = merge_strb(AXI_DATA_W'({mlkem_q, 1'b0}), s_axil_wdata_i, s_axil_wstrb_i);
    assign zero_req  = wr_en && (s_axil_awaddr_i == REG_CTRL) && ctrl_wr[2];
    // Zeroize wins over start, start while busy dropped
    assign go        = wr_en && (s_axil_awaddr_i == REG_CTRL) && ctrl_wr[0] && !zero_req && !busy;
    assign op_wr     = wr_en && (s_axil_awaddr_i inside {REG_OPA, REG_OPB});
    assign busy      = (state_q == WAIT_RESULT);
    assign capture   = busy && ready_i;

    //======================================================================
    // AXI handshakes
    //======================================================================
    // AW and W accepted together, one response outstanding at most
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            aw_ready_q <= 1'b0;
            b_valid_q  <= 1'b0;
            b_resp_q   <= RESP_OKAY;
        end else begin
            aw_ready_q <= s_axil_awvalid_i && s_axil_wvalid_i && !b_valid_q && !aw_ready_q;
            if (wr_en) begin
                b_valid_q <= 1'b1;
                b_resp_q  <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
            end else if (s_axil_bready_i) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
            r_resp_q   <= RESP_OKAY;
        end else begin
            ar_ready_q <= s_axil_arvalid_i && !r_valid_q && !ar_ready_q;
            if (rd_en) begin
                r_valid_q <= 1'b1;
                r_resp_q  <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
            end else if (s_axil_rready_i) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // Read data held stable while rvalid waits
    always_ff @(posedge clk) begin
        if (rd_en) begin
            r_data_q <= rd_data;
        end
    end

    // Read mux, unmapped gives zero data
    always_comb begin
        rd_data   = '0;
        rd_mapped = 1'b1;
        case (s_axil_araddr_i)
            REG_CTRL:   rd_data = AXI_DATA_W'({mlkem_q, 1'b0});
            REG_OPA:    rd_data = AXI_DATA_W'(opa_q);
            REG_OPB:    rd_data = AXI_DATA_W'(opb_q);
            REG_STATUS: rd_data = AXI_DATA_W'({done_q, busy});
            REG_SUM:    rd_data = AXI_DATA_W'(sum_q);
            REG_DIFF:   rd_data = AXI_DATA_W'(diff_q);
            default:    rd_mapped = 1'b0;
        endcase
    end

    //======================================================================
    // Launch controller and registers
    //======================================================================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q   <= IDLE;
            mlkem_q   <= 1'b0;
            done_q    <= 1'b0;
            start_q   <= 1'b0;
            zeroize_q <= 1'b0;
        end else begin
            // Self-clearing pulses, one cycle after the write
            start_q   <= go;
            zeroize_q <= zero_req;
            if (wr_en && (s_axil_awaddr_i == REG_CTRL)) begin
                mlkem_q <= ctrl_wr[1];
            end
            case (state_q)
                IDLE:        if (go) state_q <= WAIT_RESULT;
                WAIT_RESULT: if (zero_req || ready_i) state_q <= IDLE;
                default:     state_q <= IDLE;
            endcase
            if (go || op_wr || zero_req) begin
                done_q <= 1'b0;
            end else if (capture) begin
                done_q <= 1'b1;
            end
        end
    end

    // Operands and results, wiped by zeroize
    always_ff @(posedge clk) begin
        if (zero_req) begin
            opa_q  <= '0;
            opb_q  <= '0;
            sum_q  <= '0;
            diff_q <= '0;
        end else begin
            if (wr_en && (s_axil_awaddr_i == REG_OPA)) begin
                opa_q <= coeff_t'(merge_strb(AXI_DATA_W'(opa_q), s_axil_wdata_i, s_axil_wstrb_i));
            end
            if (wr_en && (s_axil_awaddr_i == REG_OPB)) begin
                opb_q <= coeff_t'(merge_strb(AXI_DATA_W'(opb_q), s_axil_wdata_i, s_axil_wstrb_i));
            end
            if (capture) begin
                sum_q  <= sum_i;
                diff_q <= diff_i;
            end
        end
    end

    assign s_axil_awready_o = aw_ready_q;
    assign s_axil_wready_o  = aw_ready_q;
    assign s_axil_bvalid_o  = b_valid_q;
    assign s_axil_bresp_o   = b_resp_q;
    assign s_axil_arready_o = ar_ready_q;
    assign s_axil_rvalid_o  = r_valid_q;
    assign s_axil_rresp_o   = r_resp_q;
    assign s_axil_rdata_o   = r_data_q;
    assign start_o          = start_q;
    assign zeroize_o        = zeroize_q;
    assign mlkem_o          = mlkem_q;
    assign opa_o            = opa_q;
    assign opb_o            = opb_q;

    // Responses stay up until the master takes them
    assert property (@(posedge clk) disable iff (!reset_n)
        s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o);

    assert property (@(posedge clk) disable iff (!reset_n)
        s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o && $stable(s_axil_rdata_o));

endmodule

/* rtl/ntt_butterfly_top.sv */
`timescale 1ns/1ps
//======================================================================
// Top level of the NTT butterfly engine
// AXI4-Lite register block driving one modular add/sub butterfly
//======================================================================

module ntt_butterfly_top
    import ntt_params_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  axi_addr_t  s_axil_awaddr_i,
    input  logic       s_axil_awvalid_i,
    output logic       s_axil_awready_o,
    input  axi_data_t  s_axil_wdata_i,
    input  axi_strb_t  s_axil_wstrb_i,
    input  logic       s_axil_wvalid_i,
    output logic       s_axil_wready_o,
    output logic [1:0] s_axil_bresp_o,
    output logic       s_axil_bvalid_o,
    input  logic       s_axil_bready_i,
    input  axi_addr_t  s_axil_araddr_i,
    input  logic       s_axil_arvalid_i,
    output logic       s_axil_arready_o,
    output axi_data_t  s_axil_rdata_o,
    output logic [1:0] s_axil_rresp_o,
    output logic       s_axil_rvalid_o,
    input  logic       s_axil_rready_i
);

    // Register block to butterfly
    logic   start;
    logic   zeroize;
    logic   mlkem;
    coeff_t opa;
    coeff_t opb;
    // Butterfly to register block
    coeff_t sum;
    coeff_t diff;
    logic   ready;

    ntt_axil_regs u_regs (
        .clk              (clk),
        .reset_n          (reset_n),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wstrb_i   (s_axil_wstrb_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .sum_i            (sum),
        .diff_i           (diff),
        .ready_i          (ready),
        .start_o          (start),
        .zeroize_o        (zeroize),
        .mlkem_o          (mlkem),
        .opa_o            (opa),
        .opb_o            (opb)
    );

    ntt_butterfly u_butterfly (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize),
        .start_i   (start),
        .mlkem_i   (mlkem),
        .opa_i     (opa),
        .opb_i     (opb),
        .sum_o     (sum),
        .diff_o    (diff),
        .ready_o   (ready)
    );

endmodule

/* verification/tb_ntt_butterfly_top.sv */
`timescale 1ns/1ps
//======================================================================
// Testbench for the NTT butterfly engine top level
// Drives the AXI4-Lite port, runs the cases of the test data file and
// a set of seeded random cases, and checks each result against the
// modular sum and difference computed here
//======================================================================

module tb_ntt_butterfly_top
    import ntt_params_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 64;
    localparam int POLL_LIMIT     = 32;

    logic       clk;
    logic       reset_n;
    axi_addr_t  awaddr;
    logic       awvalid;
    logic       awready;
    axi_data_t  wdata;
    axi_strb_t  wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axi_addr_t  araddr;
    logic       arvalid;
    logic       arready;
    axi_data_t  rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;
    integer     seed;

    ntt_butterfly_top u_ntt_butterfly_top (
        .clk              (clk),
        .reset_n          (reset_n),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wstrb_i   (wstrb),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_bresp_o   (bresp),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_araddr_i  (araddr),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready)
    );

    // 100 ns period
    always #50 clk = ~clk;

    //======================================================================
    // Error handling and reference model
    //======================================================================
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch at %0t: %s, expected %h, actual %h",
                                $time, what, expected, actual));
        end
    endtask

    // ML-KEM 3329 when mode is set, else ML-DSA 8380417
    function automatic logic [31:0] modulus(input logic mode);
        return mode ? 32'd3329 : 32'd8380417;
    endfunction

    function automatic logic [31:0] ref_sum(input logic mode, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [32:0] s;
        s = {1'b0, a} + {1'b0, b};
        return 32'(s % {1'b0, modulus(mode)});
    endfunction

    // Adding q first keeps the 33-bit value positive for a < b
    function automatic logic [31:0] ref_diff(input logic mode, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [32:0] s;
        s = {1'b0, a} + {1'b0, modulus(mode)} - {1'b0, b};
        return 32'(s % {1'b0, modulus(mode)});
    endfunction

    //======================================================================
    // AXI4-Lite master tasks that start and end 1 ns after a rising edge
    //======================================================================
    task automatic axil_write(input axi_addr_t addr, input axi_data_t data,
                              output logic [1:0] resp);
        int cycles;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        cycles  = 0;
        while (!awready) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("timeout: awready never rose on write");
        end
        check_value(32'(1'b1), 32'(wready), "wready together with awready");
        // Handshake happens on this edge
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        cycles  = 0;
        while (!bvalid) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("timeout: bvalid never rose on write");
        end
        resp = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    // stall holds rready low for that many cycles once rvalid is up
    task automatic axil_read(input axi_addr_t addr, input int stall,
                             output axi_data_t data, output logic [1:0] resp);
        int        cycles;
        axi_data_t held;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        cycles  = 0;
        while (!arready) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("timeout: arready never rose on read");
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        cycles  = 0;
        while (!rvalid) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("timeout: rvalid never rose on read");
        end
        held = rdata;
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            #1;
            check_value(32'(1'b1), 32'(rvalid), "rvalid held while rready low");
            check_value(held, rdata, "rdata stable while rready low");
        end
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    //======================================================================
    // Butterfly operations
    //======================================================================
    task automatic wait_done();
        axi_data_t  status;
        logic [1:0] resp;
        int         polls;
        status = '0;
        polls  = 0;
        while (!status[1]) begin
            axil_read(REG_STATUS, 0, status, resp);
            polls++;
            if (polls > POLL_LIMIT) abort_run("timeout: STATUS done never set after start");
        end
        check_value(32'd0, 32'(status[0]), "STATUS busy clear with done");
    endtask

    task automatic start_op(input logic mode);
        logic [1:0] resp;
        axil_write(REG_CTRL, {30'd0, mode, 1'b1}, resp);
        check_value(32'd0, 32'(resp), "bresp of CTRL start write");
        wait_done();
    endtask

    task automatic run_case(input logic mode, input axi_data_t a, input axi_data_t b);
        axi_data_t  got;
        logic [1:0] resp;
        string      tag;
        tag = $sformatf("mode %0d a %h b %h", mode, a, b);
        axil_write(REG_OPA, a, resp);
        check_value(32'd0, 32'(resp), {"bresp of OPA write, ", tag});
        axil_write(REG_OPB, b, resp);
        check_value(32'd0, 32'(resp), {"bresp of OPB write, ", tag});
        start_op(mode);
        axil_read(REG_SUM, 0, got, resp);
        if (mode) check_value(32'd0, got & 32'hFFFF_F000, {"SUM upper bits, ", tag});
        check_value(ref_sum(mode, a, b), got, {"SUM, ", tag});
        axil_read(REG_DIFF, 0, got, resp);
        if (mode) check_value(32'd0, got & 32'hFFFF_F000, {"DIFF upper bits, ", tag});
        check_value(ref_diff(mode, a, b), got, {"DIFF, ", tag});
    endtask

    // Each data line holds mode, a, b, expected sum and expected diff in hex
    task automatic run_file_cases();
        int          fd;
        int          n;
        int          count;
        string       line;
        logic [31:0] mode;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] fsum;
        logic [31:0] fdiff;
        count = 0;
        fd = $fopen("verification/ntt_testdata.txt", "r");
        if (fd == 0) abort_run("cannot open verification/ntt_testdata.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", mode, a, b, fsum, fdiff);
                if (n != 5) abort_run({"malformed line in test data file: ", line});
                check_value(ref_sum(mode[0], a, b), fsum, "file sum against modular rule");
                check_value(ref_diff(mode[0], a, b), fdiff, "file diff against modular rule");
                run_case(mode[0], a, b);
                count++;
            end
        end
        $fclose(fd);
        if (count == 0) abort_run("test data file holds no cases");
    endtask

    // Operands reduced below the prime of the drawn mode
    task automatic run_random_cases();
        integer    r;
        logic      mode;
        axi_data_t a;
        axi_data_t b;
        for (int i = 0; i < 20; i++) begin
            r    = $random(seed);
            mode = r[0];
            r    = $random(seed);
            a    = $unsigned(r) % modulus(mode);
            r    = $random(seed);
            b    = $unsigned(r) % modulus(mode);
            run_case(mode, a, b);
        end
    endtask

    //======================================================================
    // Main sequence
    //======================================================================
    initial begin
        axi_data_t  got;
        logic [1:0] resp;
        clk     = 1'b0;
        reset_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '1;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        seed    = 44127;
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(posedge clk);
        #1;
        check_value(32'd0, 32'({awready, wready, bvalid, arready, rvalid}),
                    "AXI handshake outputs after reset");
        axil_read(REG_STATUS, 0, got, resp);
        check_value(32'd0, got, "STATUS after reset");

        // ML-DSA and ML-KEM cases from the data file
        run_file_cases();

        // done clears on an operand write and sets again on completion
        axil_read(REG_STATUS, 0, got, resp);
        check_value(32'd2, got, "STATUS done after completed start");
        axil_write(REG_OPA, 32'd9, resp);
        axil_read(REG_STATUS, 0, got, resp);
        check_value(32'd0, got, "STATUS done cleared by OPA write");
        start_op(1'b0);

        // Unmapped address answers SLVERR with zero read data
        axil_write(8'h20, 32'h1234_5678, resp);
        check_value(32'd2, 32'(resp), "bresp of unmapped write");
        axil_read(8'h20, 0, got, resp);
        check_value(32'd2, 32'(resp), "rresp of unmapped read");
        check_value(32'd0, got, "rdata of unmapped read");
        axil_write(REG_OPA, 32'hFFAB_CDEF, resp);
        check_value(32'd0, 32'(resp), "bresp of OPA write");
        axil_read(REG_OPA, 0, got, resp);
        check_value(32'd0, 32'(resp), "rresp of OPA read");
        check_value(32'h00AB_CDEF, got, "OPA readback with top byte cleared");

        // Read back-pressure on SUM
        run_case(1'b0, 32'h7F_E000, 32'h00_0123);
        axil_read(REG_SUM, 6, got, resp);
        check_value(ref_sum(1'b0, 32'h7F_E000, 32'h00_0123), got, "SUM after rready stall");

        // Zeroize wipes operands and results
        run_case(1'b1, 32'd100, 32'd200);
        axil_write(REG_CTRL, 32'h4, resp);
        axil_read(REG_OPA, 0, got, resp);
        check_value(32'd0, got, "OPA after zeroize");
        axil_read(REG_OPB, 0, got, resp);
        check_value(32'd0, got, "OPB after zeroize");
        axil_read(REG_SUM, 0, got, resp);
        check_value(32'd0, got, "SUM after zeroize");
        axil_read(REG_DIFF, 0, got, resp);
        check_value(32'd0, got, "DIFF after zeroize");
        run_case(1'b1, 32'h123, 32'hCDE);

        run_random_cases();

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* verification/ntt_testdata.txt */
# Columns in hex: mode (0 ML-DSA q=8380417, 1 ML-KEM q=3329), operand a,
# operand b, expected (a+b) mod q, expected (a-b) mod q
0 000001 000002 000003 7FE000
0 7FE000 000001 000000 7FDFFF
0 7FE000 7FE000 7FDFFF 000000
0 000000 000000 000000 000000
0 400000 3FF001 001000 000FFF
0 123456 654321 777777 2CD136
0 7FE000 000000 7FE000 7FE000
0 000000 7FE000 7FE000 000001
1 001 002 003 D00
1 D00 D00 CFF 000
1 D00 001 000 CFF
1 800 700 1FF 100
1 100 C00 D00 201
1 9AB 7CD 477 1DE
1 000 D00 D00 001
1 680 681 000 D00

/* verilog.f */
rtl/ntt_params_pkg.sv
rtl/ntt_add_sub_mod.sv
rtl/ntt_butterfly.sv
rtl/ntt_axil_regs.sv
rtl/ntt_butterfly_top.sv
verification/tb_ntt_butterfly_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
# The exit status is zero only when the run prints the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ntt_butterfly_top -f verilog.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^NO ERRORS$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
